//--- tb.f
+incdir+.
dcache_pkg.sv
dcache_tag_store.sv
dcache_line_ram.sv
dcache_refill.sv
dcache_writeback.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

//--- run.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dcache -f tb.f > build.log 2>&1 &&
    ./obj_dir/Vtb_dcache > sim.log 2>&1
grep -qx '>>> PASS' sim.log && echo "Simulation passed" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- tb_dcache.sv
`timescale 1ns/1ps

`include "dcache_defs.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam int TIMEOUT   = 1000;
    localparam int RAND_OPS  = 3000;
    localparam int MEM_WORDS = 8192;

    logic                  clk;
    logic                  rst;
    logic                  den;
    logic [`DC_BE_W-1:0]   dwen;
    logic [`DC_ADDR_W-1:0] daddr;
    word_t                 wdata;
    logic                  data_ok;
    word_t                 data_data;
    logic                  busy;
    logic [`DC_ADDR_W-1:0] daddr_req;
    logic                  read_en;
    logic                  daddr_req_ok;
    word_t                 ddata_rdata;
    logic                  ddata_rvalid;
    logic                  ddata_rlast;
    logic [`DC_ADDR_W-1:0] daddr_wreq;
    logic                  write_en;
    logic [`DC_BE_W-1:0]   write_byte_en;
    logic                  dwvalid;
    word_t                 dwdata;
    logic                  dwlast;
    logic                  daddr_wreq_ok;
    logic                  ddata_wready;
    logic                  ddata_bvalid;

    word_t                ref_mem [MEM_WORDS];   // Architectural memory
    logic [`DC_LINES-1:0] line_valid;
    logic [`DC_LINES-1:0] line_dirty;
    tag_t                 line_tag [`DC_LINES];
    word_t                exp_word;
    logic [31:0]          lfsr;

    dcache_top DUT (.*);

    tb_mem_model mem_model (.*);

    always #50 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    function automatic word_t initial_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    endfunction

    function automatic word_t byte_merge(input word_t old_w, input word_t new_w,
                                         input logic [3:0] be);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    // Reference value of a load
    function automatic word_t expected_load(input logic [31:0] addr);
        return ref_mem[addr[14:2]];
    endfunction

    // Four tags and eight spread indices
    function automatic logic [31:0] make_addr(input logic [1:0] tsel, input logic [2:0] isel,
                                              input logic [3:0] off);
        return {17'd0, tsel, isel, 4'd0, off, 2'b00};
    endfunction

    task automatic check_writeback(input logic exp_wb, input int wb_before,
                                   input logic [31:0] victim);
        logic [12:0] word_addr;
        if (!exp_wb) begin
            assert (mem_model.wb_count == wb_before)
                else stop_with_error("A write burst was sent for a clean or invalid line");
        end else begin
            assert (mem_model.wb_count == wb_before + 1)
                else stop_with_error("A dirty victim line was not written back");
            assert (mem_model.last_waddr == victim)
                else stop_with_error($sformatf("** Error at %0t: write-back address %h, expected %h",
                                               $time, mem_model.last_waddr, victim));
            assert (mem_model.last_beats == `DC_WORDS)
                else stop_with_error($sformatf("** Error at %0t: write burst of %0d beats",
                                               $time, mem_model.last_beats));
            for (int w = 0; w < `DC_WORDS; w++) begin
                word_addr = {victim[14:6], w[3:0]};
                assert (mem_model.mem[word_addr] === ref_mem[word_addr])
                    else stop_with_error($sformatf("** Error at %0t: memory at %h is %h, expected %h",
                        $time, {word_addr, 2'b00}, mem_model.mem[word_addr], ref_mem[word_addr]));
            end
        end
    endtask

    // One processor access, held until data_ok
    task automatic do_access(input logic [31:0] addr, input logic [3:0] be, input word_t data);
        int          cycles;
        int          wb_before;
        logic        exp_hit;
        logic        exp_wb;
        tag_t        tag;
        index_t      idx;
        logic [31:0] victim;
        @(posedge clk);
        tag       = addr[31:13];
        idx       = addr[12:6];
        exp_hit   = line_valid[idx] && (line_tag[idx] == tag);
        exp_wb    = !exp_hit && line_valid[idx] && line_dirty[idx];
        victim    = {line_tag[idx], idx, 6'b0};
        exp_word  = expected_load(addr);
        wb_before = mem_model.wb_count;
        den   <= 1'b1;
        dwen  <= be;
        daddr <= addr;
        wdata <= data;
        cycles = 0;
        @(negedge clk);
        while (!data_ok) begin
            assert (busy)
                else stop_with_error($sformatf("** Error at %0t: busy low during access to %h",
                                               $time, addr));
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_error($sformatf("Timeout: no data_ok for the access to %h", addr));
            end
            @(negedge clk);
        end
        assert (exp_hit == (cycles == 0))
            else stop_with_error($sformatf("** Error at %0t: access to %h waited %0d cycles as a %s",
                                           $time, addr, cycles, exp_hit ? "hit" : "miss"));
        check_writeback(exp_wb, wb_before, victim);
        ref_mem[addr[14:2]] = byte_merge(ref_mem[addr[14:2]], data, be);
        if (!exp_hit) begin
            line_valid[idx] = 1'b1;
            line_tag[idx]   = tag;
            line_dirty[idx] = |be;   // Write-allocate leaves a store miss dirty
        end else if (|be) begin
            line_dirty[idx] = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && den && data_ok) begin
            if (dwen == '0) begin
                assert (data_data === exp_word)
                    else stop_with_error($sformatf("** Error at %0t: load %h returned %h, expected %h",
                                                   $time, daddr, data_data, exp_word));
            end else begin
                assert (data_data === '0)
                    else stop_with_error($sformatf("** Error at %0t: store %h returned data %h",
                                                   $time, daddr, data_data));
            end
        end
    end

    initial begin
        logic [31:0] bits;
        logic [31:0] addr;
        logic [3:0]  be;
        word_t       data;
        clk = 1'b0;
        rst   <= 1'b1;
        den   <= 1'b0;
        dwen  <= '0;
        daddr <= '0;
        wdata <= '0;
        lfsr = 32'd39;
        line_valid = '0;
        line_dirty = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = initial_word(32'(i) << 2);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        do_access(make_addr(2'd0, 3'd0, 4'd3), 4'h0, '0);   // Cold miss
        do_access(make_addr(2'd0, 3'd0, 4'd3), 4'h0, '0);   // Same line hits
        do_access(make_addr(2'd0, 3'd0, 4'd5), 4'b0101, 32'hDEAD_BEEF);
        do_access(make_addr(2'd0, 3'd0, 4'd5), 4'h0, '0);
        // Store miss merges into the refill
        do_access(make_addr(2'd1, 3'd1, 4'd7), 4'b1100, 32'h1234_5678);
        do_access(make_addr(2'd1, 3'd1, 4'd7), 4'h0, '0);
        do_access(make_addr(2'd2, 3'd0, 4'd9), 4'h0, '0);   // Evicts the dirty line
        do_access(make_addr(2'd0, 3'd0, 4'd5), 4'h0, '0);

        for (int n = 0; n < RAND_OPS; n++) begin
            draw_bits(9, bits);
            addr = make_addr(bits[1:0], bits[4:2], bits[8:5]);
            draw_bits(1, bits);
            if (bits[0]) begin
                draw_bits(4, bits);
                be = (bits[3:0] == 4'h0) ? 4'hF : bits[3:0];
                draw_bits(32, data);
                do_access(addr, be, data);
            end else begin
                do_access(addr, 4'h0, '0);
            end
        end

        @(posedge clk);
        den  <= 1'b0;
        dwen <= '0;
        @(posedge clk);
        $display("Write bursts seen: %0d", mem_model.wb_count);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        read_en,
    input  logic [31:0] daddr_req,
    output logic        daddr_req_ok,
    output logic [31:0] ddata_rdata,
    output logic        ddata_rvalid,
    output logic        ddata_rlast,
    input  logic        write_en,
    input  logic [31:0] daddr_wreq,
    input  logic [3:0]  write_byte_en,
    input  logic        dwvalid,
    input  logic [31:0] dwdata,
    input  logic        dwlast,
    output logic        daddr_wreq_ok,
    output logic        ddata_wready,
    output logic        ddata_bvalid
);

    logic [31:0] mem [8192];   // Word array over byte address bits 14:2
    logic [31:0] lfsr;
    logic [31:0] merged;
    logic        r_busy;
    logic        w_busy;
    logic        w_done;
    logic [8:0]  r_line;
    logic [8:0]  w_line;
    logic [3:0]  r_cnt;
    logic [3:0]  w_cnt;
    logic [31:0] last_waddr;
    int          last_beats;
    int          wb_count;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    initial begin
        lfsr = 32'd39;
        daddr_req_ok  <= 1'b0;
        ddata_rdata   <= '0;
        ddata_rvalid  <= 1'b0;
        ddata_rlast   <= 1'b0;
        daddr_wreq_ok <= 1'b0;
        ddata_wready  <= 1'b0;
        ddata_bvalid  <= 1'b0;
        wb_count      <= 0;
        for (int i = 0; i < 8192; i++) begin
            mem[i] <= (32'(i) << 2) * 32'h9E37_79B1 ^ 32'hC3A5_5A3C;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            lfsr = 32'd39;
            r_busy        <= 1'b0;
            w_busy        <= 1'b0;
            w_done        <= 1'b0;
            daddr_req_ok  <= 1'b0;
            ddata_rvalid  <= 1'b0;
            ddata_rlast   <= 1'b0;
            daddr_wreq_ok <= 1'b0;
            ddata_wready  <= 1'b0;
            ddata_bvalid  <= 1'b0;
        end else begin
            // One stall bit per channel per cycle
            lfsr = lfsr_step(lfsr);
            if (!r_busy) begin
                ddata_rvalid <= 1'b0;
                ddata_rlast  <= 1'b0;
                daddr_req_ok <= lfsr[0] && !(read_en && daddr_req_ok);
                if (read_en && daddr_req_ok) begin
                    r_busy <= 1'b1;
                    r_line <= daddr_req[14:6];
                    r_cnt  <= '0;
                end
            end else begin
                daddr_req_ok <= 1'b0;
                ddata_rvalid <= lfsr[0];
                ddata_rlast  <= lfsr[0] && (r_cnt == 4'd15);
                ddata_rdata  <= mem[{r_line, r_cnt}];
                if (lfsr[0]) begin
                    r_cnt  <= r_cnt + 1'b1;
                    r_busy <= (r_cnt != 4'd15);
                end
            end

            lfsr = lfsr_step(lfsr);
            if (w_done) begin
                ddata_bvalid <= 1'b1;   // Single response pulse
                ddata_wready <= 1'b0;
                w_done       <= 1'b0;
                w_busy       <= 1'b0;
                wb_count     <= wb_count + 1;
            end else if (!w_busy) begin
                ddata_bvalid  <= 1'b0;
                ddata_wready  <= 1'b0;
                daddr_wreq_ok <= lfsr[0] && !(write_en && daddr_wreq_ok);
                if (write_en && daddr_wreq_ok) begin
                    w_busy     <= 1'b1;
                    w_line     <= daddr_wreq[14:6];
                    w_cnt      <= '0;
                    last_waddr <= daddr_wreq;
                end
            end else begin
                daddr_wreq_ok <= 1'b0;
                ddata_wready  <= lfsr[0] && !(dwvalid && ddata_wready && dwlast);
                if (dwvalid && ddata_wready) begin
                    merged = mem[{w_line, w_cnt}];
                    for (int b = 0; b < 4; b++) begin
                        if (write_byte_en[b]) begin
                            merged[8*b +: 8] = dwdata[8*b +: 8];
                        end
                    end
                    mem[{w_line, w_cnt}] <= merged;
                    w_cnt <= w_cnt + 1'b1;
                    if (dwlast) begin
                        w_done     <= 1'b1;
                        last_beats <= int'(w_cnt) + 1;
                    end
                end
            end
        end
    end

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // Processor port
    input  logic                  den,
    input  logic [`DC_BE_W-1:0]   dwen,
    input  logic [`DC_ADDR_W-1:0] daddr,
    input  word_t                 wdata,
    output logic                  data_ok,
    output word_t                 data_data,
    output logic                  busy,

    // Memory read channel
    output logic [`DC_ADDR_W-1:0] daddr_req,
    output logic                  read_en,
    input  logic                  daddr_req_ok,
    input  word_t                 ddata_rdata,
    input  logic                  ddata_rvalid,
    input  logic                  ddata_rlast,

    // Memory write channel
    output logic [`DC_ADDR_W-1:0] daddr_wreq,
    output logic                  write_en,
    output logic [`DC_BE_W-1:0]   write_byte_en,
    output logic                  dwvalid,
    output word_t                 dwdata,
    output logic                  dwlast,
    input  logic                  daddr_wreq_ok,
    input  logic                  ddata_wready,
    input  logic                  ddata_bvalid
);

    tag_t    tag;
    index_t  index;
    offset_t offset;

    logic    hit;
    logic    victim_dirty;
    tag_t    victim_tag;
    logic    fill_commit;
    logic    fill_dirty;
    logic    store_hit;
    logic    wb_start;
    logic    wb_busy;
    logic    ram_we;
    logic    refill_active;
    line_t   rline;
    line_t   wline;
    line_t   fill_line;

    assign tag    = daddr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign index  = daddr[`DC_OFFSET_W+2 +: `DC_INDEX_W];
    assign offset = daddr[2 +: `DC_OFFSET_W];

    // Loads see the word being returned on the RAM write side; stores return zero
    assign data_data = (data_ok && !(|dwen)) ? wline[offset] : '0;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .den           (den),
        .dwen          (dwen),
        .daddr         (daddr),
        .wdata         (wdata),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .rline         (rline),
        .fill_line     (fill_line),
        .wb_busy       (wb_busy),
        .daddr_req_ok  (daddr_req_ok),
        .ddata_rlast   (ddata_rlast),
        .data_ok       (data_ok),
        .busy          (busy),
        .read_en       (read_en),
        .daddr_req     (daddr_req),
        .fill_commit   (fill_commit),
        .fill_dirty    (fill_dirty),
        .store_hit     (store_hit),
        .wb_start      (wb_start),
        .ram_we        (ram_we),
        .refill_active (refill_active),
        .wline         (wline)
    );

    dcache_tag_store u_tag_store (
        .clk          (clk),
        .rst          (rst),
        .index        (index),
        .tag          (tag),
        .fill_commit  (fill_commit),
        .fill_dirty   (fill_dirty),
        .store_hit    (store_hit),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_line_ram u_line_ram (
        .clk   (clk),
        .index (index),
        .we    (ram_we),
        .wline (wline),
        .rline (rline)
    );

    dcache_refill u_refill (
        .clk       (clk),
        .rst       (rst),
        .active    (refill_active),
        .rvalid    (ddata_rvalid),
        .rdata     (ddata_rdata),
        .offset    (offset),
        .dwen      (dwen),
        .wdata     (wdata),
        .fill_line (fill_line)
    );

    dcache_writeback u_writeback (
        .clk           (clk),
        .rst           (rst),
        .wb_start      (wb_start),
        .victim_tag    (victim_tag),
        .index         (index),
        .victim_line   (rline),
        .daddr_wreq    (daddr_wreq),
        .write_en      (write_en),
        .dwvalid       (dwvalid),
        .dwlast        (dwlast),
        .write_byte_en (write_byte_en),
        .dwdata        (dwdata),
        .daddr_wreq_ok (daddr_wreq_ok),
        .ddata_wready  (ddata_wready),
        .ddata_bvalid  (ddata_bvalid),
        .wb_busy       (wb_busy)
    );

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  den,
    input  logic [`DC_BE_W-1:0]   dwen,
    input  logic [`DC_ADDR_W-1:0] daddr,
    input  word_t                 wdata,
    input  logic                  hit,
    input  logic                  victim_dirty,
    input  line_t                 rline,
    input  line_t                 fill_line,
    input  logic                  wb_busy,
    input  logic                  daddr_req_ok,
    input  logic                  ddata_rlast,
    output logic                  data_ok,
    output logic                  busy,
    output logic                  read_en,
    output logic [`DC_ADDR_W-1:0] daddr_req,
    output logic                  fill_commit,
    output logic                  fill_dirty,
    output logic                  store_hit,
    output logic                  wb_start,
    output logic                  ram_we,
    output logic                  refill_active,
    output line_t                 wline
);

    ctrl_state_t state, state_nxt;
    offset_t     offset;
    logic        store;
    line_t       merged;

    assign offset = daddr[`DC_OFFSET_W+1:2];
    assign store  = |dwen;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Hit line with the store folded in; a load leaves it unchanged
    always_comb begin
        merged         = rline;
        merged[offset] = merge_bytes(rline[offset], wdata, dwen);
    end

    assign wline      = (state == COMMIT) ? fill_line : merged;
    assign fill_dirty = store;

    always_comb begin
        state_nxt     = state;
        data_ok       = 1'b0;
        busy          = 1'b1;
        read_en       = 1'b0;
        daddr_req     = '0;
        fill_commit   = 1'b0;
        store_hit     = 1'b0;
        wb_start      = 1'b0;
        ram_we        = 1'b0;
        refill_active = 1'b0;
        case (state)
            IDLE: begin
                busy = den && !hit;
                if (den && hit) begin
                    data_ok   = 1'b1;
                    store_hit = store;
                    ram_we    = store;
                end else if (den) begin
                    read_en   = 1'b1;
                    daddr_req = {daddr[`DC_ADDR_W-1:`DC_OFFSET_W+2], {(`DC_OFFSET_W + 2){1'b0}}};
                    wb_start  = victim_dirty;   // Victim goes out alongside the refill
                    state_nxt = daddr_req_ok ? MISS_RECEIVE : MISS_SHAKE;
                end
            end
            MISS_SHAKE: begin
                read_en   = 1'b1;
                daddr_req = {daddr[`DC_ADDR_W-1:`DC_OFFSET_W+2], {(`DC_OFFSET_W + 2){1'b0}}};
                if (daddr_req_ok) begin
                    state_nxt = MISS_RECEIVE;
                end
            end
            MISS_RECEIVE: begin
                refill_active = 1'b1;
                if (ddata_rlast) begin
                    state_nxt = wb_busy ? WB_WAIT : COMMIT;
                end
            end
            WB_WAIT: begin
                if (!wb_busy) begin   // Victim fully read out of the RAM
                    state_nxt = COMMIT;
                end
            end
            COMMIT: begin
                data_ok     = 1'b1;
                fill_commit = 1'b1;
                ram_we      = 1'b1;
                state_nxt   = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    assert property (@(posedge clk) disable iff (rst) (state != IDLE) |-> busy)
        else $error("busy low outside IDLE");

endmodule

//--- dcache_writeback.sv
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_writeback import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_start,
    input  tag_t                  victim_tag,
    input  index_t                index,
    input  line_t                 victim_line,
    output logic [`DC_ADDR_W-1:0] daddr_wreq,
    output logic                  write_en,
    output logic                  dwvalid,
    output logic                  dwlast,
    output logic [`DC_BE_W-1:0]   write_byte_en,
    output word_t                 dwdata,
    input  logic                  daddr_wreq_ok,
    input  logic                  ddata_wready,
    input  logic                  ddata_bvalid,
    output logic                  wb_busy
);

    wb_state_t state, state_nxt;
    tag_t      tag_q;
    index_t    index_q;
    offset_t   out_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_start) begin
            tag_q   <= victim_tag;
            index_q <= index;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != WB_SEND) begin
            out_cnt <= '0;
        end else if (ddata_wready) begin
            out_cnt <= out_cnt + 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        write_en  = 1'b0;
        dwvalid   = 1'b0;
        dwlast    = 1'b0;
        case (state)
            WB_IDLE: begin
                if (wb_start) begin
                    state_nxt = WB_SHAKE;
                end
            end
            WB_SHAKE: begin
                write_en = 1'b1;
                if (daddr_wreq_ok) begin
                    state_nxt = WB_SEND;
                end
            end
            WB_SEND: begin
                dwvalid = 1'b1;
                dwlast  = &out_cnt;
                if (dwlast && ddata_wready) begin
                    state_nxt = WB_RESULT;
                end
            end
            WB_RESULT: begin
                if (ddata_bvalid) begin
                    state_nxt = WB_IDLE;
                end
            end
            default: state_nxt = WB_IDLE;
        endcase
    end

    assign daddr_wreq    = {tag_q, index_q, {(`DC_OFFSET_W + 2){1'b0}}};
    assign dwdata        = victim_line[out_cnt];   // RAM still holds the victim here
    assign write_byte_en = {`DC_BE_W{dwvalid}};
    assign wb_busy       = (state != WB_IDLE);

    assert property (@(posedge clk) disable iff (rst) dwlast |-> dwvalid)
        else $error("dwlast without dwvalid");

    // Controller must wait for the previous victim before issuing another
    assert property (@(posedge clk) disable iff (rst) wb_start |-> !wb_busy)
        else $error("wb_start while write-back busy");

endmodule

//--- dcache_refill.sv
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_refill import dcache_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               active,
    input  logic               rvalid,
    input  word_t              rdata,
    input  offset_t            offset,
    input  logic [`DC_BE_W-1:0] dwen,
    input  word_t              wdata,
    output line_t              fill_line
);

    offset_t beat_cnt;
    line_t   buffer;

    always_ff @(posedge clk) begin
        if (rst || !active) begin
            beat_cnt <= '0;
        end else if (rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;   // Wraps to zero after the last beat
        end
    end

    always_ff @(posedge clk) begin
        if (active && rvalid) begin
            if (|dwen && beat_cnt == offset) begin
                buffer[beat_cnt] <= merge_bytes(rdata, wdata, dwen);   // Store miss
            end else begin
                buffer[beat_cnt] <= rdata;
            end
        end
    end

    assign fill_line = buffer;

endmodule

//--- dcache_line_ram.sv
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_line_ram import dcache_pkg::*; (
    input  logic   clk,
    input  index_t index,
    input  logic   we,
    input  line_t  wline,
    output line_t  rline
);

    line_t mem [`DC_LINES];

    // Asynchronous read, as in a distributed RAM
    assign rline = mem[index];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wline;
        end
    end

endmodule

//--- dcache_tag_store.sv
`timescale 1ns/1ps

`include "dcache_defs.svh"

module dcache_tag_store import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  index_t index,
    input  tag_t   tag,
    input  logic   fill_commit,
    input  logic   fill_dirty,
    input  logic   store_hit,
    output logic   hit,
    output logic   victim_dirty,
    output tag_t   victim_tag
);

    logic [`DC_LINES-1:0] valid;
    logic [`DC_LINES-1:0] dirty;
    tag_t                 tags [`DC_LINES];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_commit) begin
            valid[index] <= 1'b1;
            dirty[index] <= fill_dirty;   // Store miss leaves the line dirty
        end else if (store_hit) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_commit) begin
            tags[index] <= tag;
        end
    end

    assign hit          = valid[index] && (tags[index] == tag);
    assign victim_dirty = dirty[index];
    assign victim_tag   = tags[index];

    // Commit only happens outside IDLE, store hits only in IDLE
    assert property (@(posedge clk) disable iff (rst) !(fill_commit && store_hit))
        else $error("fill_commit and store_hit asserted together");

endmodule

//--- dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;
    typedef logic [`DC_WORD_W-1:0]   word_t;

    typedef logic [`DC_WORDS-1:0][`DC_WORD_W-1:0] line_t;

    typedef enum logic [3:0] {
        IDLE,
        MISS_SHAKE,
        MISS_RECEIVE,
        WB_WAIT,
        COMMIT
    } ctrl_state_t;

    typedef enum logic [2:0] {
        WB_IDLE,
        WB_SHAKE,
        WB_SEND,
        WB_RESULT
    } wb_state_t;

    // Byte-enable merge of a store into an existing word
    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input logic [`DC_BE_W-1:0] be);
        word_t mask;
        for (int i = 0; i < `DC_BE_W; i++) begin
            mask[8*i +: 8] = {8{be[i]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

endpackage

//--- dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Address is split into tag, index, word offset and byte
`define DC_ADDR_W    32
`define DC_TAG_W     19
`define DC_INDEX_W   7
`define DC_OFFSET_W  4

// Line geometry
`define DC_LINES     128
`define DC_WORDS     16   // Also the burst length

`define DC_WORD_W    32
`define DC_BE_W      4

`endif
